/* run_sim.sh */
#!/bin/sh
# Build and run the sprite renderer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f sprite_render.f --top-module tb_sprite_render -o vtb

out=$(./obj_dir/vtb)
echo "$out"

if echo "$out" | grep -qx "Verification passed"; then
    exit 0
fi
exit 1

/* sprite_render.f */
src/sprite_pkg.sv
src/raster_timing.sv
src/sprite_bitgen.sv
src/sprite_fetch_arbiter.sv
src/sprite_ram.sv
src/sprite_compositor.sv
src/sprite_render.sv
test/tb_sprite_render.sv

/* src/raster_timing.sv */
/* Raster timing generator
   Horizontal and vertical counters with sync pulses and active-area flag */
`timescale 1ns/1ns
`default_nettype none

module raster_timing #(
    parameter int H_ACTIVE = 640,
    parameter int H_FRONT  = 16,
    parameter int H_SYNC   = 96,
    parameter int H_BACK   = 48,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT  = 10,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 33
) (
    input  wire                      pix_clk,
    input  wire                      rst,
    output sprite_pkg::raster_pos_t  pos,
    output sprite_pkg::sync_t        sync
);

    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    localparam int H_SYNC_START = H_ACTIVE + H_FRONT;
    localparam int V_SYNC_START = V_ACTIVE + V_FRONT;

    logic [9:0] h_next;
    logic [9:0] v_next;

    // Next scan position, wrapping at line and frame ends
    always_comb begin
        h_next = pos.hcount + 10'd1;
        v_next = pos.vcount;
        if (int'(pos.hcount) == H_TOTAL - 1) begin
            h_next = '0;
            if (int'(pos.vcount) == V_TOTAL - 1) begin
                v_next = '0;
            end else begin
                v_next = pos.vcount + 10'd1;
            end
        end
    end

    // Outputs are computed from the next position so all fields stay aligned
    always_ff @(posedge pix_clk) begin
        if (rst) begin
            pos.hcount <= '0;
            pos.vcount <= '0;
            // Pixel (0,0) lies inside the active area
            pos.bright <= 1'b1;
            sync       <= '1;
        end else begin
            pos.hcount <= h_next;
            pos.vcount <= v_next;
            pos.bright <= (int'(h_next) < H_ACTIVE) && (int'(v_next) < V_ACTIVE);
            sync.hsync <= !((int'(h_next) >= H_SYNC_START) &&
                            (int'(h_next) < H_SYNC_START + H_SYNC));
            sync.vsync <= !((int'(v_next) >= V_SYNC_START) &&
                            (int'(v_next) < V_SYNC_START + V_SYNC));
        end
    end

    a_hcount_range: assert property (
        @(posedge pix_clk) disable iff (rst) int'(pos.hcount) < H_TOTAL
    );

endmodule

`default_nettype wire

/* src/sprite_bitgen.sv */
/* Sprite bit generator
   Hit test and texel address for one sprite, plus RGB565 to RGB888 expansion */
`timescale 1ns/1ns
`default_nettype none

module sprite_bitgen #(
    parameter int                    ADDR_WIDTH    = 12,
    parameter int                    SPRITE_WIDTH  = 16,
    parameter int                    SPRITE_HEIGHT = 16,
    parameter int                    SCALE         = 2,
    parameter logic [ADDR_WIDTH-1:0] BASE_ADDR     = '0
) (
    input  wire                      pix_clk,
    input  sprite_pkg::raster_pos_t  pos,
    input  sprite_pkg::sprite_pos_t  sprite,
    input  wire                      bright_d1,
    input  wire [15:0]               pix_data,
    input  wire                      data_valid,
    output logic                     hit,
    output logic [ADDR_WIDTH-1:0]    req_addr,
    output sprite_pkg::rgb888_t      color,
    output logic                     opaque
);

    localparam int SCALED_WIDTH      = SPRITE_WIDTH * SCALE;
    localparam int SCALED_HEIGHT     = SPRITE_HEIGHT * SCALE;
    localparam int PIXELS_PER_SPRITE = SPRITE_WIDTH * SPRITE_HEIGHT;

    logic [10:0] x_end;
    logic [10:0] y_end;
    logic        in_x;
    logic        in_y;
    logic [9:0]  off_x;
    logic [9:0]  off_y;
    logic [9:0]  tex_x;
    logic [9:0]  tex_y;

    // Extra bit keeps the right and bottom edges from wrapping
    assign x_end = {1'b0, sprite.pos_x} + 11'(SCALED_WIDTH);
    assign y_end = {1'b0, sprite.pos_y} + 11'(SCALED_HEIGHT);

    assign in_x = (pos.hcount >= sprite.pos_x) && ({1'b0, pos.hcount} < x_end);
    assign in_y = (pos.vcount >= sprite.pos_y) && ({1'b0, pos.vcount} < y_end);

    // Screen offset inside the sprite, then down to texel coordinates
    assign off_x = pos.hcount - sprite.pos_x;
    assign off_y = pos.vcount - sprite.pos_y;
    assign tex_x = 10'(off_x / SCALE);
    assign tex_y = 10'(off_y / SCALE);

    assign hit      = pos.bright && in_x && in_y;
    assign req_addr = BASE_ADDR +
                      ADDR_WIDTH'(int'(tex_y) * SPRITE_WIDTH + int'(tex_x));

    // Returned texel, valid one cycle after the request
    always_comb begin
        if (!data_valid || !bright_d1 || pix_data == sprite_pkg::TRANSPARENT_RGB565) begin
            opaque = 1'b0;
            color  = sprite_pkg::BG_COLOR;
        end else begin
            opaque  = 1'b1;
            // Replicate the top bits to fill the low end of each channel
            color.r = {pix_data[15:11], pix_data[15:13]};
            color.g = {pix_data[10:5], pix_data[10:9]};
            color.b = {pix_data[4:0], pix_data[4:2]};
        end
    end

    a_addr_in_region: assert property (
        @(posedge pix_clk)
        hit |-> (int'(req_addr) >= int'(BASE_ADDR)) &&
                (int'(req_addr) < int'(BASE_ADDR) + PIXELS_PER_SPRITE)
    );

endmodule

`default_nettype wire

/* src/sprite_compositor.sv */
/* Sprite compositor
   Picks the opaque sprite color or background and registers it with the syncs */
`timescale 1ns/1ns
`default_nettype none

module sprite_compositor #(
    parameter int NUM_SPRITES = 2
) (
    input  wire                                         pix_clk,
    input  wire                                         rst,
    input  sprite_pkg::rgb888_t [NUM_SPRITES-1:0]       color,
    input  wire [NUM_SPRITES-1:0]                       opaque,
    input  sprite_pkg::sync_t                           sync_in,
    input  wire                                         bright_d1,
    output sprite_pkg::rgb888_t                         pixel,
    output sprite_pkg::sync_t                           sync_out,
    output logic                                        bright_out
);

    sprite_pkg::rgb888_t pixel_next;
    sprite_pkg::sync_t   sync_d1;

    // At most one sprite is opaque since only the granted one sees data
    always_comb begin
        pixel_next = sprite_pkg::BG_COLOR;
        for (int i = 0; i < NUM_SPRITES; i++) begin
            if (opaque[i]) begin
                pixel_next = color[i];
            end
        end
        if (!bright_d1) begin
            pixel_next = '0;
        end
    end

    always_ff @(posedge pix_clk) begin
        if (rst) begin
            pixel      <= '0;
            sync_d1    <= '1;
            sync_out   <= '1;
            bright_out <= 1'b0;
        end else begin
            pixel      <= pixel_next;
            // Two stages to match the fetch and output registers
            sync_d1    <= sync_in;
            sync_out   <= sync_d1;
            bright_out <= bright_d1;
        end
    end

endmodule

`default_nettype wire

/* src/sprite_fetch_arbiter.sv */
/* Sprite fetch arbiter
   Fixed-priority grant of the single sprite RAM read port */
`timescale 1ns/1ns
`default_nettype none

module sprite_fetch_arbiter #(
    parameter int NUM_SPRITES = 2,
    parameter int ADDR_WIDTH  = 12
) (
    input  wire                                    pix_clk,
    input  wire                                    rst,
    input  wire [NUM_SPRITES-1:0]                  hit,
    input  wire [NUM_SPRITES-1:0][ADDR_WIDTH-1:0]  req_addr,
    input  wire                                    bright,
    output logic                                   rd_en,
    output logic [ADDR_WIDTH-1:0]                  rd_addr,
    output logic [NUM_SPRITES-1:0]                 data_valid,
    output logic                                   bright_d1
);

    logic [NUM_SPRITES-1:0] grant;

    // Walk from the top so the lowest hitting index wins
    always_comb begin
        grant   = '0;
        rd_addr = '0;
        for (int i = NUM_SPRITES - 1; i >= 0; i--) begin
            if (hit[i]) begin
                grant    = '0;
                grant[i] = 1'b1;
                rd_addr  = req_addr[i];
            end
        end
    end

    assign rd_en = |hit;

    // Grant lines up with the RAM read data one cycle later
    always_ff @(posedge pix_clk) begin
        if (rst) begin
            data_valid <= '0;
            bright_d1  <= 1'b0;
        end else begin
            data_valid <= grant;
            bright_d1  <= bright;
        end
    end

    a_valid_onehot: assert property (
        @(posedge pix_clk) disable iff (rst) $onehot0(data_valid)
    );

endmodule

`default_nettype wire

/* src/sprite_pkg.sv */
/* Sprite renderer shared types
   Raster position, sync levels, colors and sprite placement */
`default_nettype none

package sprite_pkg;

    // Pixel currently being scanned
    typedef struct packed {
        logic [9:0] hcount;
        logic [9:0] vcount;
        logic       bright;
    } raster_pos_t;

    // Active-low sync levels
    typedef struct packed {
        logic hsync;
        logic vsync;
    } sync_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb888_t;

    // Top-left corner of a sprite on screen
    typedef struct packed {
        logic [9:0] pos_x;
        logic [9:0] pos_y;
    } sprite_pos_t;

    // Magenta texels are see-through
    localparam logic [15:0] TRANSPARENT_RGB565 = 16'hF81F;

    localparam rgb888_t BG_COLOR = '{r: 8'h88, g: 8'hCC, b: 8'h88};

endpackage

`default_nettype wire

/* src/sprite_ram.sv */
/* Sprite texel memory
   Single-clock RGB565 block RAM with one write port and a registered read */
`timescale 1ns/1ns
`default_nettype none

module sprite_ram #(
    parameter int ADDR_WIDTH = 12,
    parameter int DEPTH      = 512
) (
    input  wire                   pix_clk,
    input  wire                   we,
    input  wire [ADDR_WIDTH-1:0]  waddr,
    input  wire [15:0]            wdata,
    input  wire                   rd_en,
    input  wire [ADDR_WIDTH-1:0]  rd_addr,
    output logic [15:0]           rd_data
);

    localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [15:0] mem [DEPTH];

    // Read before write on a same-address collision
    always_ff @(posedge pix_clk) begin
        if (we && int'(waddr) < DEPTH) begin
            mem[waddr[IDX_W-1:0]] <= wdata;
        end
        if (rd_en) begin
            rd_data <= mem[rd_addr[IDX_W-1:0]];
        end
    end

endmodule

`default_nettype wire

/* src/sprite_render.sv */
/* Sprite renderer top level
   Raster timing, sprite generators, fetch arbiter, sprite RAM and compositor */
`timescale 1ns/1ns
`default_nettype none

module sprite_render #(
    parameter int NUM_SPRITES   = 2,
    parameter int ADDR_WIDTH    = 12,
    parameter int SPRITE_WIDTH  = 16,
    parameter int SPRITE_HEIGHT = 16,
    parameter int SCALE         = 2,
    parameter int H_ACTIVE      = 640,
    parameter int H_FRONT       = 16,
    parameter int H_SYNC        = 96,
    parameter int H_BACK        = 48,
    parameter int V_ACTIVE      = 480,
    parameter int V_FRONT       = 10,
    parameter int V_SYNC        = 2,
    parameter int V_BACK        = 33
) (
    input  wire                                        pix_clk,
    input  wire                                        rst,
    input  sprite_pkg::sprite_pos_t [NUM_SPRITES-1:0]  sprites,
    input  wire                                        ram_we,
    input  wire [ADDR_WIDTH-1:0]                       ram_waddr,
    input  wire [15:0]                                 ram_wdata,
    output sprite_pkg::rgb888_t                        pixel,
    output logic                                       hsync,
    output logic                                       vsync,
    output logic                                       bright_out
);

    sprite_pkg::raster_pos_t                  pos;
    sprite_pkg::sync_t                        sync_raw;
    sprite_pkg::sync_t                        sync_out;
    logic [NUM_SPRITES-1:0]                   hit;
    logic [NUM_SPRITES-1:0][ADDR_WIDTH-1:0]   req_addr;
    logic [NUM_SPRITES-1:0]                   data_valid;
    logic [NUM_SPRITES-1:0]                   opaque;
    sprite_pkg::rgb888_t [NUM_SPRITES-1:0]    color;
    logic                                     rd_en;
    logic [ADDR_WIDTH-1:0]                    rd_addr;
    logic [15:0]                              rd_data;
    logic                                     bright_d1;

    raster_timing #(
        .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
    ) u_timing (
        .pix_clk(pix_clk),
        .rst(rst),
        .pos(pos),
        .sync(sync_raw)
    );

    // Each sprite owns a contiguous block of texels in the shared RAM
    for (genvar i = 0; i < NUM_SPRITES; i++) begin : g_sprite
        sprite_bitgen #(
            .ADDR_WIDTH(ADDR_WIDTH),
            .SPRITE_WIDTH(SPRITE_WIDTH),
            .SPRITE_HEIGHT(SPRITE_HEIGHT),
            .SCALE(SCALE),
            .BASE_ADDR(ADDR_WIDTH'(i * SPRITE_WIDTH * SPRITE_HEIGHT))
        ) u_bitgen (
            .pix_clk(pix_clk),
            .pos(pos),
            .sprite(sprites[i]),
            .bright_d1(bright_d1),
            .pix_data(rd_data),
            .data_valid(data_valid[i]),
            .hit(hit[i]),
            .req_addr(req_addr[i]),
            .color(color[i]),
            .opaque(opaque[i])
        );
    end

    sprite_fetch_arbiter #(
        .NUM_SPRITES(NUM_SPRITES),
        .ADDR_WIDTH(ADDR_WIDTH)
    ) u_arbiter (
        .pix_clk(pix_clk),
        .rst(rst),
        .hit(hit),
        .req_addr(req_addr),
        .bright(pos.bright),
        .rd_en(rd_en),
        .rd_addr(rd_addr),
        .data_valid(data_valid),
        .bright_d1(bright_d1)
    );

    sprite_ram #(
        .ADDR_WIDTH(ADDR_WIDTH),
        .DEPTH(NUM_SPRITES * SPRITE_WIDTH * SPRITE_HEIGHT)
    ) u_ram (
        .pix_clk(pix_clk),
        .we(ram_we),
        .waddr(ram_waddr),
        .wdata(ram_wdata),
        .rd_en(rd_en),
        .rd_addr(rd_addr),
        .rd_data(rd_data)
    );

    sprite_compositor #(
        .NUM_SPRITES(NUM_SPRITES)
    ) u_compositor (
        .pix_clk(pix_clk),
        .rst(rst),
        .color(color),
        .opaque(opaque),
        .sync_in(sync_raw),
        .bright_d1(bright_d1),
        .pixel(pixel),
        .sync_out(sync_out),
        .bright_out(bright_out)
    );

    assign hsync = sync_out.hsync;
    assign vsync = sync_out.vsync;

endmodule

`default_nettype wire

/* test/tb_sprite_render.sv */
/* Sprite renderer testbench
   Directed tests against a per-pixel model of timing, sprites and RAM mirror */
`timescale 1ns/1ns
`default_nettype none

module tb_sprite_render;

    localparam int NUM_SPRITES = 2;
    localparam int ADDR_WIDTH  = 12;
    localparam int SPRITE_W    = 16;
    localparam int SPRITE_H    = 16;
    localparam int SCALE       = 2;
    localparam int H_ACTIVE    = 64;
    localparam int H_FRONT     = 4;
    localparam int H_SYNC      = 8;
    localparam int H_BACK      = 4;
    localparam int V_ACTIVE    = 40;
    localparam int V_FRONT     = 2;
    localparam int V_SYNC      = 2;
    localparam int V_BACK      = 4;
    localparam int H_TOTAL     = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL     = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int FRAME       = H_TOTAL * V_TOTAL;
    localparam int TEXELS      = SPRITE_W * SPRITE_H;
    localparam int RAM_DEPTH   = NUM_SPRITES * TEXELS;
    localparam int HS_START    = H_ACTIVE + H_FRONT;
    localparam int VS_START    = V_ACTIVE + V_FRONT;
    // Six tests take about 13 frames and one full RAM load
    localparam int LIMIT       = 16 * FRAME + 2 * RAM_DEPTH;
    localparam logic [15:0] KEY = 16'hF81F;
    localparam sprite_pkg::rgb888_t BG = '{r: 8'h88, g: 8'hCC, b: 8'h88};

    // Expected output of one scanned pixel; src 0 none, 1/2 sprite, 3 transparent
    typedef struct packed {
        sprite_pkg::rgb888_t pix;
        logic                hs;
        logic                vs;
        logic                br;
        logic [1:0]          src;
    } entry_t;

    logic                                       pix_clk = 1'b0;
    logic                                       rst;
    sprite_pkg::sprite_pos_t [NUM_SPRITES-1:0]  sprites;
    logic                                       ram_we;
    logic [ADDR_WIDTH-1:0]                      ram_waddr;
    logic [15:0]                                ram_wdata;
    sprite_pkg::rgb888_t                        pixel;
    logic                                       hsync;
    logic                                       vsync;
    logic                                       bright_out;

    logic [15:0] mirror [RAM_DEPTH];
    logic [31:0] lcg_state = 32'he856;
    string       test_name = "reset";
    entry_t      pipe0;
    entry_t      pipe1;
    int          mh;
    int          mv;
    int          cycles = 0;
    int          checks = 0;
    int          errors = 0;
    int          frames_done = 0;
    int          acc_hs;
    int          acc_vs;
    int          acc_br;
    int          acc_s0;
    int          acc_s1;
    int          acc_tr;
    int          last_hs;
    int          last_vs;
    int          last_br;
    int          last_s0;
    int          last_s1;
    int          last_tr;

    sprite_render #(
        .NUM_SPRITES(NUM_SPRITES), .ADDR_WIDTH(ADDR_WIDTH),
        .SPRITE_WIDTH(SPRITE_W), .SPRITE_HEIGHT(SPRITE_H), .SCALE(SCALE),
        .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
    ) u_dut (
        .pix_clk(pix_clk),
        .rst(rst),
        .sprites(sprites),
        .ram_we(ram_we),
        .ram_waddr(ram_waddr),
        .ram_wdata(ram_wdata),
        .pixel(pixel),
        .hsync(hsync),
        .vsync(vsync),
        .bright_out(bright_out)
    );

    always #2 pix_clk = ~pix_clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // RGB565 to RGB888 with the high bits repeated into the low end
    function automatic sprite_pkg::rgb888_t expand565(input logic [15:0] t);
        sprite_pkg::rgb888_t c;
        c.r = {t[15:11], t[15:13]};
        c.g = {t[10:5], t[10:9]};
        c.b = {t[4:0], t[4:2]};
        return c;
    endfunction

    function automatic entry_t model_pixel(input int h, input int v);
        entry_t      e;
        int          px;
        int          py;
        int          idx;
        logic [15:0] t;
        bit          found;
        e.hs  = !(h >= HS_START && h < HS_START + H_SYNC);
        e.vs  = !(v >= VS_START && v < VS_START + V_SYNC);
        e.br  = (h < H_ACTIVE) && (v < V_ACTIVE);
        e.pix = '0;
        e.src = 2'd0;
        found = 1'b0;
        if (e.br) begin
            e.pix = BG;
            // Lowest index wins, even where its texel is transparent
            for (int i = 0; i < NUM_SPRITES; i++) begin
                px = int'(sprites[i].pos_x);
                py = int'(sprites[i].pos_y);
                if (!found && h >= px && h < px + SPRITE_W * SCALE &&
                    v >= py && v < py + SPRITE_H * SCALE) begin
                    found = 1'b1;
                    idx = i * TEXELS + ((v - py) / SCALE) * SPRITE_W + (h - px) / SCALE;
                    t = mirror[idx];
                    if (t == KEY) begin
                        e.src = 2'd3;
                    end else begin
                        e.pix = expand565(t);
                        e.src = 2'(i + 1);
                    end
                end
            end
        end
        return e;
    endfunction

    task automatic check(input string label, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("Error: %s %s expected %h actual %h", test_name, label, exp, act);
        end
    endtask

    // Model of the raster, two-stage output pipeline and RAM mirror
    always @(negedge pix_clk) begin
        if (rst) begin
            mh = 0;
            mv = 0;
            pipe0 = '{pix: '0, hs: 1'b1, vs: 1'b1, br: 1'b0, src: 2'd0};
            pipe1 = pipe0;
            check("reset pixel", 32'(24'h0), 32'(pixel));
            check("reset hsync", 32'(1'b1), 32'(hsync));
            check("reset vsync", 32'(1'b1), 32'(vsync));
            check("reset bright", 32'(1'b0), 32'(bright_out));
        end else begin
            check("pixel", 32'(pipe1.pix), 32'(pixel));
            check("hsync", 32'(pipe1.hs), 32'(hsync));
            check("vsync", 32'(pipe1.vs), 32'(vsync));
            check("bright", 32'(pipe1.br), 32'(bright_out));
            acc_hs += int'(!hsync);
            acc_vs += int'(!vsync);
            acc_br += int'(bright_out);
            acc_s0 += int'(pipe1.src == 2'd1);
            acc_s1 += int'(pipe1.src == 2'd2);
            acc_tr += int'(pipe1.src == 2'd3);
            pipe1 = pipe0;
            pipe0 = model_pixel(mh, mv);
            // The RAM reads before it writes, so the mirror updates after the model
            if (ram_we && int'(ram_waddr) < RAM_DEPTH) begin
                mirror[int'(ram_waddr)] = ram_wdata;
            end
            mh++;
            if (mh == H_TOTAL) begin
                mh = 0;
                mv++;
                if (mv == V_TOTAL) begin
                    mv = 0;
                    last_hs = acc_hs;
                    last_vs = acc_vs;
                    last_br = acc_br;
                    last_s0 = acc_s0;
                    last_s1 = acc_s1;
                    last_tr = acc_tr;
                    acc_hs = 0;
                    acc_vs = 0;
                    acc_br = 0;
                    acc_s0 = 0;
                    acc_s1 = 0;
                    acc_tr = 0;
                    frames_done++;
                end
            end
        end
    end

    always @(posedge pix_clk) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycles);
            $display("Verification failed");
            $finish;
        end
    end

    task automatic wait_frames(input int n);
        int target;
        target = frames_done + n;
        while (frames_done < target) begin
            @(posedge pix_clk);
        end
    endtask

    task automatic write_texel(input int addr, input logic [15:0] data);
        @(posedge pix_clk);
        ram_we    <= 1'b1;
        ram_waddr <= ADDR_WIDTH'(addr);
        ram_wdata <= data;
        @(posedge pix_clk);
        ram_we    <= 1'b0;
    endtask

    task automatic place_sprite(input int i, input int x, input int y);
        @(posedge pix_clk);
        sprites[i] <= '{pos_x: 10'(x), pos_y: 10'(y)};
    endtask

    task automatic sync_and_blanking();
        test_name = "sync_blank";
        wait_frames(2);
        check("hsync low cycles", 32'(H_SYNC * V_TOTAL), 32'(last_hs));
        check("vsync low cycles", 32'(V_SYNC * H_TOTAL), 32'(last_vs));
        check("bright cycles", 32'(H_ACTIVE * V_ACTIVE), 32'(last_br));
    endtask

    task automatic opaque_texels();
        logic [15:0] d;
        test_name = "opaque";
        for (int a = 0; a < RAM_DEPTH; a++) begin
            lcg_state = lcg_next(lcg_state);
            d = lcg_state[31:16];
            if (d == KEY) begin
                d = d ^ 16'h0001;
            end
            @(posedge pix_clk);
            ram_we    <= 1'b1;
            ram_waddr <= ADDR_WIDTH'(a);
            ram_wdata <= d;
        end
        @(posedge pix_clk);
        ram_we <= 1'b0;
        place_sprite(0, 10, 6);
        wait_frames(2);
        check("sprite0 pixels", 32'(TEXELS * SCALE * SCALE), 32'(last_s0));
    endtask

    task automatic transparent_texels();
        int keyed [5] = '{0, 17, 34, 100, 255};
        test_name = "transparent";
        foreach (keyed[k]) begin
            write_texel(keyed[k], KEY);
        end
        wait_frames(2);
        check("sprite0 pixels", 32'((TEXELS - 5) * SCALE * SCALE), 32'(last_s0));
        check("keyed pixels", 32'(5 * SCALE * SCALE), 32'(last_tr));
    endtask

    task automatic odd_position_scaling();
        test_name = "scaling";
        place_sprite(0, 21, 3);
        wait_frames(2);
        check("sprite0 pixels", 32'((TEXELS - 5) * SCALE * SCALE), 32'(last_s0));
    endtask

    task automatic overlap_priority();
        test_name = "overlap";
        place_sprite(1, 29, 7);
        wait_frames(2);
        check("sprite0 pixels", 32'((TEXELS - 5) * SCALE * SCALE), 32'(last_s0));
        // Overlap of 24 by 28 screen pixels belongs to sprite 0
        check("sprite1 pixels", 32'(TEXELS * SCALE * SCALE - 24 * 28), 32'(last_s1));
        check("keyed pixels", 32'(5 * SCALE * SCALE), 32'(last_tr));
    endtask

    task automatic midframe_rewrite();
        test_name = "write_midframe";
        while (mv < V_ACTIVE / 2) begin
            @(posedge pix_clk);
        end
        write_texel(0, 16'h1234);
        wait_frames(2);
        check("sprite0 pixels", 32'((TEXELS - 4) * SCALE * SCALE), 32'(last_s0));
    endtask

    initial begin
        rst       = 1'b1;
        ram_we    = 1'b0;
        ram_waddr = '0;
        ram_wdata = '0;
        // Off screen until the RAM holds data
        sprites[0] = '{pos_x: 10'd500, pos_y: 10'd500};
        sprites[1] = '{pos_x: 10'd500, pos_y: 10'd500};
        repeat (3) @(posedge pix_clk);
        rst <= 1'b0;
        sync_and_blanking();
        opaque_texels();
        transparent_texels();
        odd_position_scaling();
        overlap_priority();
        midframe_rewrite();
        $display("Checks: %0d, errors: %0d, frames: %0d", checks, errors, frames_done);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
